/* filelist.f */
source/dtlbPkg.sv
source/dtlbEntry.sv
source/dtlbArbiter.sv
source/dtlbHitMux.sv
source/dtlbResultReg.sv
source/dtlbTop.sv
test/dtlbTb.sv

/* run.sh */
#!/bin/sh
# Build the DTLB testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module dtlbTb -Mdir obj_dir
simOut=$(./obj_dir/VdtlbTb)
echo "$simOut"

if echo "$simOut" | grep -q "^No errors$"; then
  exit 0
fi
exit 1

/* test/dtlbCases.txt */
# R idx epn rpn size attr | I | T name ea real realAttr expMiss expRpn expAttr
# O idx epn rpn size attr name ea real realAttr expMiss expRpn expAttr (refill and translate together)
# Nothing valid after reset
T reset_miss_a 000000 0 00 1 000000 00
T reset_miss_b 2ABCDE 0 00 1 000000 00
# 4 KB entry in slot 0
R 0 012344 0ABC00 1 85
T k4_base 012344 0 00 0 0ABC00 85
T k4_off3 012347 0 00 0 0ABC03 85
T k4_next 012348 0 00 1 000000 00
# 16 MB entry in slot 1
R 1 1C0000 2C0000 7 12
T m16_low 1C0000 0 00 0 2C0000 12
T m16_high 1C3FFF 0 00 0 2C3FFF 12
T m16_mid 1C2A5B 0 00 0 2C2A5B 12
T m16_below 1BFFFF 0 00 1 000000 00
T m16_above 1C4000 0 00 1 000000 00
# 64 KB entry in slot 2
R 2 0007C0 3FFFC0 3 48
T k64_in 0007E5 0 00 0 3FFFE5 48
T k64_out 000800 0 00 1 000000 00
# Real mode ignores the entries
T real_hit 012344 1 A6 0 012344 A6
T real_other 355555 1 01 0 355555 01
T real_m16 1C0123 1 00 0 1C0123 00
# Invalidate all, then restore slot 1 only
I
T inv_k4 012344 0 00 1 000000 00
T inv_m16 1C0000 0 00 1 000000 00
T inv_k64 0007C0 0 00 1 000000 00
R 1 1C0000 2C0000 7 12
T rest_m16 1C1234 0 00 0 2C1234 12
T rest_k4 012344 0 00 1 000000 00
T rest_k64 0007C0 0 00 1 000000 00
# Overlapping refill and translate, result independent of order
O 4 250000 150000 2 01 ovl_hit 1C0ABC 0 00 0 2C0ABC 12
T ovl_check 25000F 0 00 0 15000F 01
O 5 300100 0A0100 0 C0 ovl_miss 012344 0 00 1 000000 00
T ovl_check2 300100 0 00 0 0A0100 C0
T ovl_exact 300101 0 00 1 000000 00
O 6 012340 099990 1 33 ovl_real 012344 1 5A 0 012344 5A
T ovl_check3 012342 0 00 0 099992 33

/* test/dtlbTb.sv */
// Testbench for the data-side shadow TLB
// Replays refill, invalidate and translate operations from a case file
// through both four-phase ports and checks every translation response

`timescale 1ns/100ps

module dtlbTb;

  import dtlbPkg::*;

  localparam int ackTimeout = 20;

  logic      CB = 1'b0;
  logic      rstN;
  logic      xlateReq;
  xlateReqT  xlateData;
  logic      xlateAck;
  xlateRspT  xlateRsp;
  logic      refillReq;
  refillReqT refillData;
  logic      refillAck;

  int   mismatchCount = 0;
  int   timeoutCount  = 0;
  int   protocolCount = 0;
  int   otherCount    = 0;
  int   caseCount     = 0;
  logic hung;
  logic xlateAckPrev  = 1'b0;
  logic refillAckPrev = 1'b0;

  dtlbTop #(
    .numEntries (8)
  ) dtlbTop_inst (
    .CB           (CB),
    .rstN_i       (rstN),
    .xlateReq_i   (xlateReq),
    .xlateData_i  (xlateData),
    .xlateAck_o   (xlateAck),
    .xlateRsp_o   (xlateRsp),
    .refillReq_i  (refillReq),
    .refillData_i (refillData),
    .refillAck_o  (refillAck)
  );

  // 100 ns clock period
  always
  begin
    #50 CB = ~CB;
  end

  // **************************************************************************
  // Checking
  // **************************************************************************

  task automatic checkValue(input string testName, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      mismatchCount++;
      $display("MISMATCH %0s %0s expected %0h actual %0h",
               testName, field, expected, actual);
    end
  endtask

  // On a miss the empty OR-merge leaves page and attributes at zero
  task automatic checkResponse(input string testName, input xlateRspT rsp,
                               input logic expMiss, input logic [21:0] expRpn,
                               input logic [7:0] expAttr);
    checkValue(testName, "miss", {31'b0, expMiss}, {31'b0, rsp.miss});
    checkValue(testName, "rpn", {10'b0, expRpn}, {10'b0, rsp.rpn});
    checkValue(testName, "attr", {24'b0, expAttr}, {24'b0, rsp.attr});
  endtask

  // An ack may only rise while its req is up
  always @(negedge CB)
  begin
    if (xlateAck && !xlateAckPrev && !xlateReq)
    begin
      $display("Translate ack rose while translate req was low");
      protocolCount++;
    end
    if (refillAck && !refillAckPrev && !refillReq)
    begin
      $display("Refill ack rose while refill req was low");
      protocolCount++;
    end
    xlateAckPrev  = xlateAck;
    refillAckPrev = refillAck;
  end

  // **************************************************************************
  // Handshake drivers
  // **************************************************************************

  task automatic runTranslate(input xlateReqT req, output xlateRspT rsp);
    int waitCount;
    rsp = '0;
    @(posedge CB);
    xlateData <= req;
    xlateReq  <= 1'b1;
    waitCount = 0;
    do
    begin
      @(negedge CB);
      waitCount++;
    end
    while (xlateAck !== 1'b1 && waitCount < ackTimeout);
    if (xlateAck !== 1'b1)
    begin
      $display("Translate port hung, ack never rose");
      timeoutCount++;
      hung = 1'b1;
    end
    else
    begin
      rsp = xlateRsp;
      @(posedge CB);
      xlateReq <= 1'b0;
      waitCount = 0;
      do
      begin
        @(negedge CB);
        waitCount++;
      end
      while (xlateAck !== 1'b0 && waitCount < ackTimeout);
      if (xlateAck !== 1'b0)
      begin
        $display("Translate port hung, ack never fell");
        timeoutCount++;
        hung = 1'b1;
      end
    end
  endtask

  task automatic runRefill(input refillReqT req);
    int waitCount;
    @(posedge CB);
    refillData <= req;
    refillReq  <= 1'b1;
    waitCount = 0;
    do
    begin
      @(negedge CB);
      waitCount++;
    end
    while (refillAck !== 1'b1 && waitCount < ackTimeout);
    if (refillAck !== 1'b1)
    begin
      $display("Refill port hung, ack never rose");
      timeoutCount++;
      hung = 1'b1;
    end
    else
    begin
      @(posedge CB);
      refillReq <= 1'b0;
      waitCount = 0;
      do
      begin
        @(negedge CB);
        waitCount++;
      end
      while (refillAck !== 1'b0 && waitCount < ackTimeout);
      if (refillAck !== 1'b0)
      begin
        $display("Refill port hung, ack never fell");
        timeoutCount++;
        hung = 1'b1;
      end
    end
  endtask

  // **************************************************************************
  // Case file replay
  // **************************************************************************

  initial
  begin
    int               fd;
    int               code;
    logic             done;
    logic [7:0]       op;
    logic [8*24-1:0]  nameVec;
    logic [8*128-1:0] skipLine;
    logic [2:0]       idx;
    logic [2:0]       size;
    logic [21:0]      epn;
    logic [21:0]      rpn;
    logic [21:0]      ea;
    logic [21:0]      expRpn;
    logic [7:0]       attr;
    logic [7:0]       realAttr;
    logic [7:0]       expAttr;
    logic             realMode;
    logic             expMiss;
    string            caseName;
    refillReqT        rfData;
    xlateReqT         xrData;
    xlateRspT         rspGot;

    rstN       <= 1'b0;
    xlateReq   <= 1'b0;
    xlateData  <= '0;
    refillReq  <= 1'b0;
    refillData <= '0;
    hung = 1'b0;
    repeat (3) @(posedge CB);
    rstN <= 1'b1;

    @(negedge CB);
    checkValue("reset", "xlateAck", 32'd0, {31'b0, xlateAck});
    checkValue("reset", "refillAck", 32'd0, {31'b0, refillAck});
    checkValue("reset", "xlateRsp", 32'd0, {1'b0, xlateRsp});

    fd = $fopen("test/dtlbCases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file test/dtlbCases.txt");
      otherCount++;
    end
    done = (fd == 0);

    while (!done)
    begin
      code = $fscanf(fd, " %c", op);
      if (code != 1)
      begin
        done = 1'b1;
      end
      else
      begin
        rfData = '0;
        xrData = '0;
        case (op)
          "#":
          begin
            code = $fgets(skipLine, fd);
          end
          "I":
          begin
            rfData.invalidateAll = 1'b1;
            runRefill(rfData);
          end
          "R", "O":
          begin
            code = $fscanf(fd, "%h %h %h %h %h", idx, epn, rpn, size, attr);
            rfData.index      = idx;
            rfData.entry.epn  = epn;
            rfData.entry.rpn  = rpn;
            rfData.entry.size = size;
            rfData.entry.attr = attr;
            if (code != 5)
            begin
              $display("Malformed refill fields in the case file");
              otherCount++;
              done = 1'b1;
            end
            else if (op == "R")
            begin
              runRefill(rfData);
            end
          end
          "T":
          begin
          end
          default:
          begin
            $display("Unknown operation in the case file");
            otherCount++;
            done = 1'b1;
          end
        endcase

        // Translate fields follow on T lines and on overlap lines
        if (!done && (op == "T" || op == "O"))
        begin
          code = $fscanf(fd, "%s %h %h %h %h %h %h", nameVec, ea, realMode, realAttr,
                         expMiss, expRpn, expAttr);
          if (code != 7)
          begin
            $display("Malformed translate fields in the case file");
            otherCount++;
            done = 1'b1;
          end
          else
          begin
            caseName        = $sformatf("%0s", nameVec);
            xrData.ea       = ea;
            xrData.realMode = realMode;
            xrData.realAttr = realAttr;
            if (op == "O")
            begin
              // Both requests rise on the same edge
              fork
                runRefill(rfData);
                runTranslate(xrData, rspGot);
              join
            end
            else
            begin
              runTranslate(xrData, rspGot);
            end
            if (!hung)
            begin
              caseCount++;
              checkResponse(caseName, rspGot, expMiss, expRpn, expAttr);
            end
          end
        end
        if (hung)
        begin
          done = 1'b1;
        end
      end
    end

    if (fd != 0)
    begin
      $fclose(fd);
    end

    $display("Summary: %0d translations, %0d mismatches, %0d timeouts, %0d protocol, %0d other",
             caseCount, mismatchCount, timeoutCount, protocolCount, otherCount);
    if (mismatchCount + timeoutCount + protocolCount + otherCount == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* source/dtlbTop.sv */
// Data-side shadow TLB top level
// Arbiter, entry array, hit merge and capture register behind a
// four-phase translate port and a four-phase refill port

`timescale 1ns/100ps

module dtlbTop
#(
  parameter int numEntries = 8
)
(
  input  logic               CB,
  input  logic               rstN_i,
  input  logic               xlateReq_i,
  input  dtlbPkg::xlateReqT  xlateData_i,
  output logic               xlateAck_o,
  output dtlbPkg::xlateRspT  xlateRsp_o,
  input  logic               refillReq_i,
  input  dtlbPkg::refillReqT refillData_i,
  output logic               refillAck_o
);

  import dtlbPkg::*;

  logic                  lookupGrant;
  logic                  invalidate;
  logic [numEntries-1:0] writeSel;
  logic [numEntries-1:0] hits;
  tlbEntryT              entries [numEntries];
  xlateRspT              rspComb;

  dtlbArbiter #(
    .numEntries (numEntries)
  ) dtlbArbiter_inst (
    .CB                 (CB),
    .rstN_i             (rstN_i),
    .xlateReq_i         (xlateReq_i),
    .refillReq_i        (refillReq_i),
    .refillIndex_i      (refillData_i.index),
    .refillInvalidate_i (refillData_i.invalidateAll),
    .xlateAck_o         (xlateAck_o),
    .refillAck_o        (refillAck_o),
    .lookupGrant_o      (lookupGrant),
    .writeSel_o         (writeSel),
    .invalidate_o       (invalidate)
  );

  // Entry array, all compare the same page
  for (genvar g = 0; g < numEntries; g++)
  begin : genEntry
    dtlbEntry dtlbEntry_inst (
      .CB           (CB),
      .rstN_i       (rstN_i),
      .writeSel_i   (writeSel[g]),
      .invalidate_i (invalidate),
      .data_i       (refillData_i.entry),
      .lookupEa_i   (xlateData_i.ea),
      .hit_o        (hits[g]),
      .entry_o      (entries[g])
    );
  end

  dtlbHitMux #(
    .numEntries (numEntries)
  ) dtlbHitMux_inst (
    .hits_i      (hits),
    .entries_i   (entries),
    .xlateData_i (xlateData_i),
    .rsp_o       (rspComb)
  );

  dtlbResultReg dtlbResultReg_inst (
    .CB        (CB),
    .rstN_i    (rstN_i),
    .capture_i (lookupGrant),
    .rsp_i     (rspComb),
    .rsp_o     (xlateRsp_o)
  );

endmodule

/* source/dtlbResultReg.sv */
// Attribute capture register
// Holds the last translation result for the whole ack phase

`timescale 1ns/100ps

module dtlbResultReg
(
  input  logic              CB,
  input  logic              rstN_i,
  input  logic              capture_i,
  input  dtlbPkg::xlateRspT rsp_i,
  output dtlbPkg::xlateRspT rsp_o
);

  // Loads on the lookup grant edge
  always_ff @(posedge CB or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      rsp_o <= '0;
    end
    else if (capture_i)
    begin
      rsp_o <= rsp_i;
    end
  end

endmodule

/* source/dtlbHitMux.sv */
// Hit merge for the entry array
// OR-merges real page and attributes of hitting entries, flags a miss
// and replaces the result with the request itself in real mode

`timescale 1ns/100ps

module dtlbHitMux
#(
  parameter int numEntries = 8
)
(
  input  logic [numEntries-1:0] hits_i,
  input  dtlbPkg::tlbEntryT     entries_i [numEntries],
  input  dtlbPkg::xlateReqT     xlateData_i,
  output dtlbPkg::xlateRspT     rsp_o
);

  import dtlbPkg::*;

  tlbAttrT             attrMerge;
  logic [pageNumW-1:0] rpnMerge;
  logic [pageNumW-1:0] sizeMask;
  logic                anyHit;

  assign anyHit = |hits_i;

  // **************************************************************************
  // Translated path
  // **************************************************************************

  // Multiple hits just OR together
  always_comb
  begin
    attrMerge = '0;
    rpnMerge  = '0;
    sizeMask  = '0;
    for (int i = 0; i < numEntries; i++)
    begin
      sizeMask = pageMask(entries_i[i].size);
      if (hits_i[i])
      begin
        attrMerge = tlbAttrT'(attrMerge | entries_i[i].attr);
        // Page offset bits come from the effective page
        rpnMerge  = rpnMerge | (entries_i[i].rpn & sizeMask)
                             | (xlateData_i.ea & ~sizeMask);
      end
    end
  end

  // **************************************************************************
  // Output select
  // **************************************************************************

  always_comb
  begin
    if (xlateData_i.realMode)
    begin
      rsp_o.miss = 1'b0;
      rsp_o.rpn  = xlateData_i.ea;
      rsp_o.attr = xlateData_i.realAttr;
    end
    else
    begin
      rsp_o.miss = ~anyHit;
      rsp_o.rpn  = rpnMerge;
      rsp_o.attr = attrMerge;
    end
  end

endmodule

/* source/dtlbArbiter.sv */
// Arbiter for the translate and refill ports
// Runs a four-phase req/ack on each port, grants the entry array to
// one port for a single cycle and alternates priority under contention

`timescale 1ns/100ps

module dtlbArbiter
#(
  parameter int numEntries = 8,
  parameter int idxW       = $clog2(numEntries)
)
(
  input  logic                  CB,
  input  logic                  rstN_i,
  input  logic                  xlateReq_i,
  input  logic                  refillReq_i,
  input  logic [idxW-1:0]       refillIndex_i,
  input  logic                  refillInvalidate_i,
  output logic                  xlateAck_o,
  output logic                  refillAck_o,
  output logic                  lookupGrant_o,
  output logic [numEntries-1:0] writeSel_o,
  output logic                  invalidate_o
);

  logic lookupGrant;
  logic writeGrant;
  logic prioRefill;
  logic busy;
  logic xlateWait;
  logic refillWait;
  logic pickXlate;
  logic pickRefill;

  // A port waits while req is up and its ack has not yet been given
  assign busy       = lookupGrant | writeGrant;
  assign xlateWait  = xlateReq_i & ~xlateAck_o;
  assign refillWait = refillReq_i & ~refillAck_o;

  // Refill goes first only if alone or holding priority
  assign pickRefill = ~busy & refillWait & (~xlateWait | prioRefill);
  assign pickXlate  = ~busy & xlateWait & ~pickRefill;

  always_ff @(posedge CB or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      lookupGrant <= 1'b0;
      writeGrant  <= 1'b0;
      prioRefill  <= 1'b0;
      xlateAck_o  <= 1'b0;
      refillAck_o <= 1'b0;
    end
    else
    begin
      lookupGrant <= pickXlate;
      writeGrant  <= pickRefill;

      // Hand priority to the port just passed over
      if (pickXlate)
      begin
        prioRefill <= 1'b1;
      end
      else if (pickRefill)
      begin
        prioRefill <= 1'b0;
      end

      // Ack follows the grant, drops once req is seen low
      if (lookupGrant)
      begin
        xlateAck_o <= 1'b1;
      end
      else if (!xlateReq_i)
      begin
        xlateAck_o <= 1'b0;
      end

      if (writeGrant)
      begin
        refillAck_o <= 1'b1;
      end
      else if (!refillReq_i)
      begin
        refillAck_o <= 1'b0;
      end
    end
  end

  assign lookupGrant_o = lookupGrant;
  assign invalidate_o  = writeGrant & refillInvalidate_i;

  // One-hot write select, payload is stable during the grant cycle
  always_comb
  begin
    writeSel_o = '0;
    for (int i = 0; i < numEntries; i++)
    begin
      if (writeGrant && !refillInvalidate_i && (refillIndex_i == idxW'(i)))
      begin
        writeSel_o[i] = 1'b1;
      end
    end
  end

endmodule

/* source/dtlbEntry.sv */
// One fully associative TLB entry
// Holds the page pair, size and attributes with a valid bit, and
// compares a lookup page under the entry's own size mask

`timescale 1ns/100ps

module dtlbEntry
(
  input  logic                            CB,
  input  logic                            rstN_i,
  input  logic                            writeSel_i,
  input  logic                            invalidate_i,
  input  dtlbPkg::tlbEntryT               data_i,
  input  logic [dtlbPkg::pageNumW-1:0]    lookupEa_i,
  output logic                            hit_o,
  output dtlbPkg::tlbEntryT               entry_o
);

  import dtlbPkg::*;

  tlbEntryT            entryQ;
  logic                valid;
  logic [pageNumW-1:0] cmpMask;

  // **************************************************************************
  // Storage
  // **************************************************************************

  // Valid bit, invalidate wins over a write
  always_ff @(posedge CB or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      valid <= 1'b0;
    end
    else if (invalidate_i)
    begin
      valid <= 1'b0;
    end
    else if (writeSel_i)
    begin
      valid <= 1'b1;
    end
  end

  // Entry payload
  always_ff @(posedge CB)
  begin
    if (writeSel_i)
    begin
      entryQ <= data_i;
    end
  end

  // **************************************************************************
  // Compare
  // **************************************************************************

  // Bits below the page size never take part
  assign cmpMask = pageMask(entryQ.size);
  assign hit_o   = valid && ((entryQ.epn & cmpMask) == (lookupEa_i & cmpMask));
  assign entry_o = entryQ;

endmodule

/* source/dtlbPkg.sv */
// Data-side shadow TLB shared definitions
// Page number widths, size-code mask rule and the structs that carry
// entries, translate requests, responses and refill requests

package dtlbPkg;

  // Page numbers in 1 KB units
  localparam int pageNumW   = 22;
  localparam int sizeCodeW  = 3;
  localparam int entryIdxW  = 3;

  // Size code n selects a 1 KB * 4**n page, code 7 is 16 MB
  function automatic logic [pageNumW-1:0] pageMask(input logic [sizeCodeW-1:0] code);
    return {pageNumW{1'b1}} << (2 * code);
  endfunction

  // Storage attributes
  typedef struct packed {
    logic       writeThru;
    logic       inhibit;
    logic       u0;
    logic       guarded;
    logic       littleEndian;
    logic [1:0] zoneSel;
    logic       writeEn;
  } tlbAttrT;

  typedef struct packed {
    logic [pageNumW-1:0]  epn;
    logic [pageNumW-1:0]  rpn;
    logic [sizeCodeW-1:0] size;
    tlbAttrT              attr;
  } tlbEntryT;

  typedef struct packed {
    logic [pageNumW-1:0] ea;
    logic                realMode;
    tlbAttrT             realAttr;
  } xlateReqT;

  typedef struct packed {
    logic                miss;
    logic [pageNumW-1:0] rpn;
    tlbAttrT             attr;
  } xlateRspT;

  typedef struct packed {
    logic                 invalidateAll;
    logic [entryIdxW-1:0] index;
    tlbEntryT             entry;
  } refillReqT;

endpackage
